// ==== verilog.f ====
rtl/mbxPkg.sv
rtl/mbLoadDecode.sv
rtl/mbWordSlot.sv
rtl/mbWordSelect.sv
rtl/mbxTop.sv
sim/mbxTb.sv

// ==== Makefile ====
# Verilator simulation of the memory buffer bookkeeping

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mbxTb
FILELIST  := verilog.f
BUILDDIR  := obj_dir
LOG       := sim.log
PASSTEXT  := *** TEST PASSED ***

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

test: build
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASSTEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== sim/mbxTb.sv ====
// Random loads and acks from a fixed seed; block loads always carry a non-empty mask
`timescale 1ns/10ps

module mbxTb;

  localparam int          NumCycles     = 3000;
  localparam int          TimeoutCycles = NumCycles + 200;
  localparam logic [31:0] Seed          = 32'hfb30_62f5;

  logic             clk;
  logic             rstN;
  logic             loadStrobe;
  logic             oneWord;
  mbxPkg::wordIdxT  wordAdr;
  mbxPkg::wordVecT  wordMask;
  logic             parIn;
  mbxPkg::dataCodeT codeIn;
  logic             memAck;
  logic             memWrRq;
  mbxPkg::wordIdxT  mbSel;
  logic             mbPar;
  mbxPkg::dataCodeT mbDataCode;
  logic             pendingAny;
  logic             xferDone;

  // Reference model state
  mbxPkg::wordVecT  mPend;
  mbxPkg::wordVecT  mPar;
  mbxPkg::dataCodeT mCode [mbxPkg::NumWords];
  logic             mSend;
  mbxPkg::wordIdxT  mSel;
  logic             mAckSeen;

  int               errCount;
  int               checkCount;
  int               cycleCount;
  int               sentCount;
  int               reloadAckCount;
  int               doneCount;

  mbxTop u_mbxTop (
    .clk        (clk),
    .rstN       (rstN),
    .loadStrobe (loadStrobe),
    .oneWord    (oneWord),
    .wordAdr    (wordAdr),
    .wordMask   (wordMask),
    .parIn      (parIn),
    .codeIn     (codeIn),
    .memAck     (memAck),
    .memWrRq    (memWrRq),
    .mbSel      (mbSel),
    .mbPar      (mbPar),
    .mbDataCode (mbDataCode),
    .pendingAny (pendingAny),
    .xferDone   (xferDone)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    errCount++;
    $display("ERR %s expected %h got %h at %0t", name, expVal, gotVal, $time);
  endtask

  // First pending word counting up from index zero
  function automatic mbxPkg::wordIdxT lowestPending(input mbxPkg::wordVecT vec);
    mbxPkg::wordIdxT idx;
    logic            found;
    idx   = '0;
    found = 1'b0;
    for (int i = 0; i < mbxPkg::NumWords; i++) begin
      if (vec[i] && !found) begin
        idx   = mbxPkg::wordIdxT'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task automatic driveInputs();
    logic [31:0]     r;
    mbxPkg::wordVecT maskVal;
    r          = $urandom();
    loadStrobe = (($urandom() % 100) < 30);
    oneWord    = r[0];
    wordAdr    = r[2:1];
    // Aim half the loads at the word being sent to hit reload cases
    if (mSend && r[9]) begin
      wordAdr = mSel;
    end
    maskVal = r[6:3];
    if (maskVal == '0) begin
      maskVal = mbxPkg::wordVecT'(1) << r[8:7];
    end
    wordMask = maskVal;
    parIn    = r[10];
    codeIn   = r[12:11];
    memAck   = (($urandom() % 100) < 40);
  endtask

  // Advance the model by one rising edge, all terms taken from the old state
  task automatic updateModel();
    mbxPkg::wordVecT setV;
    mbxPkg::wordVecT clrV;
    logic            ackTaken;
    logic            anyOld;
    mbxPkg::wordIdxT lowIdx;
    setV = '0;
    if (loadStrobe) begin
      if (oneWord) begin
        setV = mbxPkg::wordVecT'(1) << wordAdr;
      end else begin
        setV = wordMask;
      end
    end
    ackTaken = mSend && memAck;
    clrV     = ackTaken ? (mbxPkg::wordVecT'(1) << mSel) : '0;
    anyOld   = |mPend;
    lowIdx   = lowestPending(mPend);
    if (ackTaken) begin
      sentCount++;
      if (setV[mSel]) begin
        reloadAckCount++;
      end
    end
    if (!mSend && anyOld) begin
      mSend = 1'b1;
      mSel  = lowIdx;
    end else if (ackTaken) begin
      mSend = 1'b0;
    end
    mAckSeen = ackTaken;
    for (int i = 0; i < mbxPkg::NumWords; i++) begin
      if (setV[i]) begin
        mPend[i] = 1'b1;
        mPar[i]  = parIn;
        mCode[i] = codeIn;
      end else if (clrV[i]) begin
        mPend[i] = 1'b0;
      end
    end
  endtask

  // The model select only moves on entry to send, so a held request keeps mbSel
  task automatic checkOutputs();
    logic expDone;
    expDone    = mAckSeen && !(|mPend);
    checkCount = checkCount + 6;
    if (memWrRq !== mSend) reportMismatch("memWrRq", 32'(mSend), 32'(memWrRq));
    if (mbSel !== mSel) reportMismatch("mbSel", 32'(mSel), 32'(mbSel));
    if (mbPar !== mPar[mSel]) reportMismatch("mbPar", 32'(mPar[mSel]), 32'(mbPar));
    if (mbDataCode !== mCode[mSel]) begin
      reportMismatch("mbDataCode", 32'(mCode[mSel]), 32'(mbDataCode));
    end
    if (pendingAny !== (|mPend)) reportMismatch("pendingAny", 32'(|mPend), 32'(pendingAny));
    if (xferDone !== expDone) reportMismatch("xferDone", 32'(expDone), 32'(xferDone));
    if (xferDone === 1'b1) begin
      doneCount++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////

  initial begin
    void'($urandom(Seed));
    rstN           = 1'b0;
    loadStrobe     = 1'b0;
    oneWord        = 1'b0;
    wordAdr        = '0;
    wordMask       = '0;
    parIn          = 1'b0;
    codeIn         = '0;
    memAck         = 1'b0;
    errCount       = 0;
    checkCount     = 0;
    sentCount      = 0;
    reloadAckCount = 0;
    doneCount      = 0;
    mPend          = '0;
    mPar           = '0;
    for (int i = 0; i < mbxPkg::NumWords; i++) begin
      mCode[i] = '0;
    end
    mSend    = 1'b0;
    mSel     = '0;
    mAckSeen = 1'b0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    // State right out of reset
    checkCount = checkCount + 4;
    if (memWrRq !== 1'b0) reportMismatch("memWrRq", 32'h0, 32'(memWrRq));
    if (xferDone !== 1'b0) reportMismatch("xferDone", 32'h0, 32'(xferDone));
    if (pendingAny !== 1'b0) reportMismatch("pendingAny", 32'h0, 32'(pendingAny));
    if (mbSel !== '0) reportMismatch("mbSel", 32'h0, 32'(mbSel));
    rstN = 1'b1;

    for (int cyc = 0; cyc < NumCycles; cyc++) begin
      driveInputs();
      @(posedge clk);
      updateModel();
      @(negedge clk);
      checkOutputs();
    end

    $display("Words sent: %0d, reloads at ack: %0d, done pulses: %0d",
             sentCount, reloadAckCount, doneCount);
    $display("Errors: %0d of %0d checks", errCount, checkCount);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== rtl/mbxTop.sv ====
// Four-word memory buffer bookkeeping; plain strobes and levels only, memAck is honored only while memWrRq is high
`timescale 1ns/10ps

module mbxTop (
  input  logic             clk,
  input  logic             rstN,
  input  logic             loadStrobe,
  input  logic             oneWord,
  input  mbxPkg::wordIdxT  wordAdr,
  input  mbxPkg::wordVecT  wordMask,
  input  logic             parIn,
  input  mbxPkg::dataCodeT codeIn,
  input  logic             memAck,
  output logic             memWrRq,
  output mbxPkg::wordIdxT  mbSel,
  output logic             mbPar,
  output mbxPkg::dataCodeT mbDataCode,
  output logic             pendingAny,
  output logic             xferDone
);

  mbxPkg::wordVecT  setVec;
  mbxPkg::wordVecT  clrVec;
  mbxPkg::wordVecT  reqVec;
  mbxPkg::wordVecT  parVec;
  mbxPkg::dataCodeT codeArr [mbxPkg::NumWords];

  ////////////////////////////////////////
  // Load side
  ////////////////////////////////////////

  mbLoadDecode u_loadDecode (
    .clk        (clk),
    .rstN       (rstN),
    .loadStrobe (loadStrobe),
    .oneWord    (oneWord),
    .wordAdr    (wordAdr),
    .wordMask   (wordMask),
    .setVec     (setVec)
  );

  ////////////////////////////////////////
  // Buffer words
  ////////////////////////////////////////

  for (genvar i = 0; i < mbxPkg::NumWords; i++) begin : gSlot
    mbWordSlot u_wordSlot (
      .clk      (clk),
      .rstN     (rstN),
      .setWord  (setVec[i]),
      .clrWord  (clrVec[i]),
      .parIn    (parIn),
      .codeIn   (codeIn),
      .req      (reqVec[i]),
      .par      (parVec[i]),
      .dataCode (codeArr[i])
    );
  end

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  mbWordSelect u_wordSelect (
    .clk        (clk),
    .rstN       (rstN),
    .reqVec     (reqVec),
    .parVec     (parVec),
    .codeArr    (codeArr),
    .memAck     (memAck),
    .clrVec     (clrVec),
    .memWrRq    (memWrRq),
    .mbSel      (mbSel),
    .mbPar      (mbPar),
    .mbDataCode (mbDataCode),
    .pendingAny (pendingAny),
    .xferDone   (xferDone)
  );

endmodule

// ==== rtl/mbWordSelect.sv ====
// Lowest pending word goes first; select is held with no time limit until memAck, one idle cycle between words
`timescale 1ns/10ps

module mbWordSelect (
  input  logic             clk,
  input  logic             rstN,
  input  mbxPkg::wordVecT  reqVec,
  input  mbxPkg::wordVecT  parVec,
  input  mbxPkg::dataCodeT codeArr [mbxPkg::NumWords],
  input  logic             memAck,
  output mbxPkg::wordVecT  clrVec,
  output logic             memWrRq,
  output mbxPkg::wordIdxT  mbSel,
  output logic             mbPar,
  output mbxPkg::dataCodeT mbDataCode,
  output logic             pendingAny,
  output logic             xferDone
);

  mbxPkg::selStateT state;
  mbxPkg::selStateT stateNext;
  mbxPkg::wordIdxT  nextSel;
  mbxPkg::wordIdxT  selReg;
  logic             ackTaken;
  logic             ackSeen;

  ////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////

  assign pendingAny = |reqVec;

  // Scan from the top so the lowest pending index is left last
  always_comb begin
    nextSel = '0;
    for (int i = mbxPkg::NumWords - 1; i >= 0; i--) begin
      if (reqVec[i]) begin
        nextSel = mbxPkg::wordIdxT'(i);
      end
    end
  end

  ////////////////////////////////////////
  // Drain FSM
  ////////////////////////////////////////

  // Ack counts only while a request is up
  assign ackTaken = (state == mbxPkg::selSend) && memAck;

  always_comb begin
    stateNext = state;
    case (state)
      mbxPkg::selIdle: begin
        if (pendingAny) begin
          stateNext = mbxPkg::selSend;
        end
      end
      mbxPkg::selSend: begin
        if (memAck) begin
          stateNext = mbxPkg::selIdle;
        end
      end
      default: stateNext = mbxPkg::selIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= mbxPkg::selIdle;
      selReg  <= '0;
      ackSeen <= 1'b0;
    end else begin
      state   <= stateNext;
      ackSeen <= ackTaken;
      // Select is captured only on entry to selSend
      if (state == mbxPkg::selIdle && pendingAny) begin
        selReg <= nextSel;
      end
    end
  end

  ////////////////////////////////////////
  // Outputs to memory and slots
  ////////////////////////////////////////

  assign memWrRq = (state == mbxPkg::selSend);
  assign mbSel   = selReg;

  // Retire the held word at the ack edge
  assign clrVec = ackTaken ? (mbxPkg::wordVecT'(1) << selReg) : '0;

  // Status follows the slot, so a reload shows one cycle later
  assign mbPar      = parVec[selReg];
  assign mbDataCode = codeArr[selReg];

  // Done only when the last pending word was just retired
  assign xferDone = ackSeen && !pendingAny;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  selStableA: assert property (
    @(posedge clk) disable iff (!rstN)
    (memWrRq ##1 memWrRq) |-> $stable(mbSel)
  ) else $error("mbSel changed during a held request");

  // Held word must still be pending in its slot
  selPendingA: assert property (
    @(posedge clk) disable iff (!rstN)
    memWrRq |-> reqVec[selReg]
  ) else $error("request up for a word that is not pending");

endmodule

// ==== rtl/mbWordSlot.sv ====
// One buffer word; a set and a clear at the same edge keep the word pending with new parity and code
`timescale 1ns/10ps

module mbWordSlot (
  input  logic             clk,
  input  logic             rstN,
  input  logic             setWord,
  input  logic             clrWord,
  input  logic             parIn,
  input  mbxPkg::dataCodeT codeIn,
  output logic             req,
  output logic             par,
  output mbxPkg::dataCodeT dataCode
);

  ////////////////////////////////////////
  // Request flag and stored word status
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      req      <= 1'b0;
      par      <= 1'b0;
      dataCode <= '0;
    end else if (setWord) begin
      // Load wins over retire
      req      <= 1'b1;
      par      <= parIn;
      dataCode <= codeIn;
    end else if (clrWord) begin
      // Retired by the drain, status left as is
      req      <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // The drain only retires a word it picked while pending
  clrOnlyPendingA: assert property (
    @(posedge clk) disable iff (!rstN)
    clrWord |-> req
  ) else $error("word retired while not pending");

endmodule

// ==== rtl/mbLoadDecode.sv ====
// Zero-latency load decode; clk and rstN only feed the check on block loads with an empty mask
`timescale 1ns/10ps

module mbLoadDecode (
  input  logic            clk,
  input  logic            rstN,
  input  logic            loadStrobe,
  input  logic            oneWord,
  input  mbxPkg::wordIdxT wordAdr,
  input  mbxPkg::wordVecT wordMask,
  output mbxPkg::wordVecT setVec
);

  mbxPkg::wordVecT adrOneHot;
  mbxPkg::wordVecT loadSel;

  ////////////////////////////////////////
  // Word selection
  ////////////////////////////////////////

  // Single word load marks only the addressed word
  assign adrOneHot = mbxPkg::wordVecT'(1) << wordAdr;

  // Block load takes the mask as given
  always_comb begin
    if (oneWord) begin
      loadSel = adrOneHot;
    end else begin
      loadSel = wordMask;
    end
  end

  // Nothing is marked outside the strobe cycle
  assign setVec = loadStrobe ? loadSel : '0;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A block load with no words marked would be lost silently
  blockMaskNonEmptyA: assert property (
    @(posedge clk) disable iff (!rstN)
    (loadStrobe && !oneWord) |-> (wordMask != '0)
  ) else $error("block load with empty word mask");

endmodule

// ==== rtl/mbxPkg.sv ====
// Buffer is fixed at four words since a word index is two address bits; NumWords is not a knob
package mbxPkg;

  ////////////////////////////////////////
  // Buffer geometry
  ////////////////////////////////////////

  // Number of words held in the memory buffer
  localparam int NumWords = 4;

  ////////////////////////////////////////
  // Word types
  ////////////////////////////////////////

  // Index of one buffer word, used for the word address and the select
  typedef logic [$clog2(NumWords)-1:0] wordIdxT;

  // One bit per buffer word
  // Used for load masks, set and clear strobes and pending flags
  typedef logic [NumWords-1:0] wordVecT;

  // Data code stored alongside each word
  // Carried through unchanged from load to the memory side
  typedef logic [1:0] dataCodeT;

  ////////////////////////////////////////
  // Drain state machine
  ////////////////////////////////////////

  // selIdle samples the pending requests
  // selSend holds the chosen word until memory acknowledges it
  typedef enum logic {
    selIdle,
    selSend
  } selStateT;

endpackage
